// File: branch_unit.f
+incdir+hw
hw/branch_pkg.sv
hw/pipe_stage_reg.sv
hw/branch_target_buffer.sv
hw/branch_resolver.sv
hw/branch_exec_top.sv
verification/branch_exec_props.sv
verification/branch_exec_tb.sv

// File: hw/branch_config.svh
`ifndef BRANCH_CONFIG_SVH
`define BRANCH_CONFIG_SVH

// core data and address width
`define BR_XLEN 32

// direct mapped and indexed from pc bit 2 upward
`define BR_BTB_ENTRIES 16

// saturating direction counter
`define BR_CNT_W 2

`endif

// File: hw/branch_exec_top.sv
`timescale 1ns/1ps
`include "branch_config.svh"

module branch_exec_top import branch_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  br_req_t             in_req,
    output logic                res_valid,
    output br_resolve_t         res,
    output logic                redirect_valid,
    output logic [`BR_XLEN-1:0] redirect_pc
);

    br_pred_t    lookup_pred;
    ex_req_t     lookup_req;
    logic        ex_valid;
    ex_req_t     ex_req;
    br_resolve_t ex_res;
    btb_update_t btb_upd;

    // lookup stage
    branch_target_buffer u_btb (
        .clk       (clk),
        .reset     (reset),
        .lookup_pc (in_req.pc),
        .pred      (lookup_pred),
        .upd       (btb_upd)      // trains at the edge loading s2
    );

    assign lookup_req.op   = in_req;
    assign lookup_req.pred = lookup_pred;

    pipe_stage_reg #(
        .payload_t (ex_req_t)
    ) s1 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_data   (lookup_req),
        .out_valid (ex_valid),
        .out_data  (ex_req)
    );

    // execute stage
    branch_resolver u_resolver (
        .req   (ex_req),
        .valid (ex_valid),
        .res   (ex_res),
        .upd   (btb_upd)
    );

    // result stage
    pipe_stage_reg #(
        .payload_t (br_resolve_t)
    ) s2 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (ex_valid),
        .in_data   (ex_res),
        .out_valid (res_valid),
        .out_data  (res)
    );

    assign redirect_valid = res_valid && res.addr_fail;  // any wrong fetch address
    assign redirect_pc    = res.redirect_pc;

endmodule

// File: hw/branch_pkg.sv
`include "branch_config.svh"

package branch_pkg;

    // condition field of the branch uop
    typedef enum logic [3:0] {
        BR_JIRL = 4'd3,  // target from sr1
        BR_B    = 4'd4,
        BR_BL   = 4'd5,
        BR_BEQ  = 4'd6,
        BR_BNE  = 4'd7,
        BR_BLT  = 4'd8,
        BR_BGE  = 4'd9,
        BR_BLTU = 4'd10,
        BR_BGEU = 4'd11
    } br_cond_e;

    // op as it arrives from issue
    typedef struct packed {
        logic [`BR_XLEN-1:0] pc;
        logic [`BR_XLEN-1:0] imm;
        logic [`BR_XLEN-1:0] sr1;   // forwarded operands
        logic [`BR_XLEN-1:0] sr2;
        br_cond_e            cond;
        logic                is_branch;
    } br_req_t;

    typedef struct packed {
        logic                taken;
        logic [`BR_XLEN-1:0] target;
    } br_pred_t;

    // op plus what the btb said about it
    typedef struct packed {
        br_req_t  op;
        br_pred_t pred;
    } ex_req_t;

    typedef struct packed {
        logic [`BR_XLEN-1:0] pc;
        logic                taken;
        logic [`BR_XLEN-1:0] target;
        logic                dir_fail;   // wrong direction
        logic                addr_fail;  // wrong fetch address
        logic [`BR_XLEN-1:0] redirect_pc;
    } br_resolve_t;

    // training record from resolver to btb
    typedef struct packed {
        logic                valid;
        logic [`BR_XLEN-1:0] pc;
        logic                taken;
        logic [`BR_XLEN-1:0] target;
    } btb_update_t;

endpackage

// File: hw/branch_resolver.sv
`timescale 1ns/1ps
`include "branch_config.svh"

module branch_resolver import branch_pkg::*; (
    input  ex_req_t     req,
    input  logic        valid,
    output br_resolve_t res,
    output btb_update_t upd
);

    localparam int XLEN = `BR_XLEN;

    logic            sr1_eq_sr2;
    logic            sr1_lt_sr2_u;
    logic            sr1_lt_sr2_s;
    logic            cond_true;
    logic            fact_taken;
    logic [XLEN-1:0] fact_target;
    logic [XLEN-1:0] seq_pc;

    assign sr1_eq_sr2   = (req.op.sr1 == req.op.sr2);
    assign sr1_lt_sr2_u = (req.op.sr1 < req.op.sr2);
    // on differing signs a negative sr1 is less
    assign sr1_lt_sr2_s = (req.op.sr1[XLEN-1] != req.op.sr2[XLEN-1]) ?
                          req.op.sr1[XLEN-1] : sr1_lt_sr2_u;

    always_comb begin
        case (req.op.cond)
            BR_JIRL, BR_B, BR_BL: cond_true = 1'b1;  // unconditional
            BR_BEQ:  cond_true = sr1_eq_sr2;
            BR_BNE:  cond_true = !sr1_eq_sr2;
            BR_BLT:  cond_true = sr1_lt_sr2_s;
            BR_BGE:  cond_true = !sr1_lt_sr2_s;
            BR_BLTU: cond_true = sr1_lt_sr2_u;
            BR_BGEU: cond_true = !sr1_lt_sr2_u;
            default: cond_true = 1'b0;
        endcase
    end

    assign fact_taken  = req.op.is_branch && cond_true;
    assign fact_target = (req.op.cond == BR_JIRL) ? req.op.sr1 + req.op.imm
                                                  : req.op.pc + req.op.imm;
    assign seq_pc      = req.op.pc + XLEN'(4);

    // mispredict classification
    always_comb begin
        res.dir_fail  = 1'b0;
        res.addr_fail = 1'b0;
        if (fact_taken != req.pred.taken) begin
            res.dir_fail  = 1'b1;
            res.addr_fail = 1'b1;
        end else if (fact_taken && (req.pred.target != fact_target)) begin
            res.addr_fail = 1'b1;  // right direction, wrong target
        end
    end

    assign res.pc          = req.op.pc;
    assign res.taken       = fact_taken;
    assign res.target      = fact_target;
    assign res.redirect_pc = fact_taken ? fact_target : seq_pc;

    // only real branches train the btb
    assign upd.valid  = valid && req.op.is_branch;
    assign upd.pc     = req.op.pc;
    assign upd.taken  = fact_taken;
    assign upd.target = fact_target;

endmodule

// File: hw/branch_target_buffer.sv
`timescale 1ns/1ps
`include "branch_config.svh"

module branch_target_buffer import branch_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic [`BR_XLEN-1:0] lookup_pc,
    output br_pred_t            pred,
    input  btb_update_t         upd
);

    localparam int XLEN    = `BR_XLEN;
    localparam int ENTRIES = `BR_BTB_ENTRIES;
    localparam int CNT_W   = `BR_CNT_W;
    localparam int IDX_W   = $clog2(ENTRIES);
    localparam int TAG_W   = XLEN - IDX_W - 2;

    localparam logic [CNT_W-1:0] CNT_MAX  = '1;
    localparam logic [CNT_W-1:0] CNT_MIN  = '0;
    localparam logic [CNT_W-1:0] CNT_WEAK = {1'b1, {(CNT_W-1){1'b0}}};  // weakly taken

    logic [ENTRIES-1:0] ent_valid;
    logic [TAG_W-1:0]   ent_tag    [ENTRIES];
    logic [XLEN-1:0]    ent_target [ENTRIES];
    logic [CNT_W-1:0]   ent_cnt    [ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic             rd_hit;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_hit;

    // lookup side
    assign rd_idx = lookup_pc[2 +: IDX_W];
    assign rd_tag = lookup_pc[XLEN-1 -: TAG_W];
    assign rd_hit = ent_valid[rd_idx] && (ent_tag[rd_idx] == rd_tag);

    assign pred.taken  = rd_hit && ent_cnt[rd_idx][CNT_W-1];  // cnt >= weak taken
    assign pred.target = rd_hit ? ent_target[rd_idx] : lookup_pc + XLEN'(4);

    // training side
    assign wr_idx = upd.pc[2 +: IDX_W];
    assign wr_tag = upd.pc[XLEN-1 -: TAG_W];
    assign wr_hit = ent_valid[wr_idx] && (ent_tag[wr_idx] == wr_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            ent_valid <= '0;
        end else if (upd.valid && upd.taken && !wr_hit) begin
            ent_valid[wr_idx] <= 1'b1;  // allocate on taken miss
        end
    end

    always_ff @(posedge clk) begin
        if (upd.valid) begin
            if (wr_hit) begin
                if (upd.taken) begin
                    ent_target[wr_idx] <= upd.target;
                    if (ent_cnt[wr_idx] != CNT_MAX) begin
                        ent_cnt[wr_idx] <= ent_cnt[wr_idx] + 1'b1;
                    end
                end else if (ent_cnt[wr_idx] != CNT_MIN) begin
                    ent_cnt[wr_idx] <= ent_cnt[wr_idx] - 1'b1;
                end
            end else if (upd.taken) begin
                ent_tag[wr_idx]    <= wr_tag;
                ent_target[wr_idx] <= upd.target;
                ent_cnt[wr_idx]    <= CNT_WEAK;
            end
            // not taken miss leaves the entry alone
        end
    end

endmodule

// File: hw/pipe_stage_reg.sv
`timescale 1ns/1ps

module pipe_stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // payload follows valid, no back-pressure
    always_ff @(posedge clk) begin
        out_data <= in_data;
    end

endmodule

// File: verification/branch_exec_props.sv
`timescale 1ns/1ps

module branch_exec_props import branch_pkg::*; (
    input logic        clk,
    input logic        reset,
    input logic        in_valid,
    input logic        res_valid,
    input br_resolve_t res,
    input logic        redirect_valid
);

    int unsigned fail_count = 0;  // failed assertion count

    // two register stages between request and result
    latency_two: assert property (@(posedge clk) disable iff (reset)
        res_valid == $past(in_valid, 2))
        else begin
            fail_count++;
            $error("res_valid does not follow in_valid by two cycles");
        end

    dir_implies_addr: assert property (@(posedge clk) disable iff (reset)
        res_valid |-> (!res.dir_fail || res.addr_fail))
        else begin
            fail_count++;
            $error("dir_fail seen without addr_fail");
        end

    redirect_needs_valid: assert property (@(posedge clk) disable iff (reset)
        $rose(redirect_valid) |-> res_valid)
        else begin
            fail_count++;
            $error("redirect_valid rose while res_valid was low");
        end

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge clk)
        ($past(reset) && !reset) |-> !res_valid)
        else begin
            fail_count++;
            $error("res_valid set in the cycle after reset");
        end

endmodule

bind branch_exec_top branch_exec_props u_props (
    .clk            (clk),
    .reset          (reset),
    .in_valid       (in_valid),
    .res_valid      (res_valid),
    .res            (res),
    .redirect_valid (redirect_valid)
);

// File: verification/branch_exec_tb.sv
`timescale 1ns/1ps
`include "branch_config.svh"

module branch_exec_tb import branch_pkg::*; ();

    localparam int XLEN         = `BR_XLEN;
    localparam int ENTRIES      = `BR_BTB_ENTRIES;
    localparam int IDX_W        = $clog2(ENTRIES);
    localparam int CNT_MAX      = (1 << `BR_CNT_W) - 1;
    localparam int CNT_WEAK     = 1 << (`BR_CNT_W - 1);
    localparam int RESET_CYCLES = 8;
    localparam int LATENCY      = 2;
    localparam int MARGIN       = 20;

    // one line of the stim file
    typedef struct packed {
        logic [1:0]      kind;  // 0 bubble, 1 op, 2 filler
        br_req_t         req;
        logic            exp_taken;
        logic [XLEN-1:0] exp_target;
        logic [7:0]      test_id;
    } stim_t;

    logic            clk;
    logic            reset;
    logic            in_valid;
    br_req_t         in_req;
    logic            res_valid;
    br_resolve_t     res;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;

    stim_t       ops[$];
    string       test_names[int];
    br_resolve_t exp_q[$];
    logic        exp_v_q[$];
    int          exp_t_q[$];

    // btb reference model
    logic            m_valid  [ENTRIES];
    logic [XLEN-1:0] m_tag    [ENTRIES];
    logic [XLEN-1:0] m_target [ENTRIES];
    int              m_cnt    [ENTRIES];
    logic            pend_v;
    logic [XLEN-1:0] pend_pc;
    logic            pend_taken;
    logic [XLEN-1:0] pend_target;

    int n_checks = 0;
    int n_errors = 0;
    int n_tests = 0;
    int t_checks = 0;
    int t_errors = 0;
    int cur_chk = -1;
    int cycle_cnt = 0;
    int cycle_limit = 0;

    branch_exec_top DUT (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_req         (in_req),
        .res_valid      (res_valid),
        .res            (res),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic int idx_of(input logic [XLEN-1:0] pc);
        return int'((pc >> 2) % ENTRIES);
    endfunction

    function automatic logic [XLEN-1:0] tag_of(input logic [XLEN-1:0] pc);
        return pc >> (2 + IDX_W);
    endfunction

    function automatic logic model_hit(input logic [XLEN-1:0] pc);
        return m_valid[idx_of(pc)] && (m_tag[idx_of(pc)] == tag_of(pc));
    endfunction

    function automatic logic cond_holds(input br_cond_e c, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
        case (c)
            BR_JIRL, BR_B, BR_BL: return 1'b1;
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return $signed(a) < $signed(b);
            BR_BGE:  return $signed(a) >= $signed(b);
            BR_BLTU: return a < b;
            BR_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic train_model(input logic [XLEN-1:0] pc, input logic taken,
                               input logic [XLEN-1:0] target);
        int k;
        k = idx_of(pc);
        if (model_hit(pc)) begin
            if (taken) begin
                m_target[k] = target;
                if (m_cnt[k] < CNT_MAX) m_cnt[k]++;
            end else if (m_cnt[k] > 0) begin
                m_cnt[k]--;
            end
        end else if (taken) begin
            m_valid[k]  = 1'b1;
            m_tag[k]    = tag_of(pc);
            m_target[k] = target;
            m_cnt[k]    = CNT_WEAK;
        end
    endtask

    task automatic load_stim();
        int              fd;
        int              cnt;
        int              cur_tid;
        string           line;
        string           tname;
        logic [XLEN-1:0] f_valid;
        logic [XLEN-1:0] f_pc;
        logic [XLEN-1:0] f_imm;
        logic [XLEN-1:0] f_sr1;
        logic [XLEN-1:0] f_sr2;
        logic [XLEN-1:0] f_cond;
        logic [XLEN-1:0] f_br;
        logic [XLEN-1:0] f_taken;
        logic [XLEN-1:0] f_target;
        stim_t           s;
        cur_tid = 0;
        fd = $fopen("verification/branch_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stim file");
            n_errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            if (line.getc(0) == "@") begin
                cnt = $sscanf(line, "@ %d %s", cur_tid, tname);
                test_names[cur_tid] = tname;
                continue;
            end
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_valid, f_pc, f_imm,
                          f_sr1, f_sr2, f_cond, f_br, f_taken, f_target);
            if (cnt != 9) begin
                $display("stim line could not be parsed: %s", line);
                n_errors++;
                continue;
            end
            s.kind          = f_valid[1:0];
            s.req.pc        = f_pc;
            s.req.imm       = f_imm;
            s.req.sr1       = f_sr1;
            s.req.sr2       = f_sr2;
            s.req.cond      = br_cond_e'(f_cond[3:0]);
            s.req.is_branch = f_br[0];
            s.exp_taken     = f_taken[0];
            s.exp_target    = f_target;
            s.test_id       = cur_tid[7:0];
            ops.push_back(s);
        end
        $fclose(fd);
    endtask

    // drive one op and queue what the DUT should answer
    task automatic apply_op(input stim_t s);
        br_req_t         req;
        br_resolve_t     exp;
        logic            p_taken;
        logic [XLEN-1:0] p_target;
        logic            t;
        logic [XLEN-1:0] tgt;
        int              k;
        req = s.req;
        t   = s.exp_taken;
        tgt = s.exp_target;
        if (s.kind == 2'd2) begin
            req.sr2 = $urandom;
            t   = req.is_branch && cond_holds(req.cond, req.sr1, req.sr2);
            tgt = (req.cond == BR_JIRL) ? req.sr1 + req.imm : req.pc + req.imm;
        end
        k        = idx_of(req.pc);
        p_taken  = model_hit(req.pc) && (m_cnt[k] >= CNT_WEAK);
        p_target = m_target[k];
        if (pend_v) train_model(pend_pc, pend_taken, pend_target);  // older op trains after lookup
        pend_v      = (s.kind != 2'd0) && req.is_branch;
        pend_pc     = req.pc;
        pend_taken  = t;
        pend_target = tgt;
        exp.pc          = req.pc;
        exp.taken       = t;
        exp.target      = tgt;
        exp.dir_fail    = (t != p_taken);
        exp.addr_fail   = exp.dir_fail || (t && (p_target != tgt));
        exp.redirect_pc = t ? tgt : req.pc + 32'd4;
        in_valid = (s.kind != 2'd0);
        in_req   = req;
        exp_q.push_back(exp);
        exp_v_q.push_back(s.kind != 2'd0);
        exp_t_q.push_back(int'(s.test_id));
    endtask

    task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        n_checks++;
        t_checks++;
        if (got !== exp) begin
            $display("FAILED t=%0t %s got %h exp %h", $time, name, got, exp);
            n_errors++;
            t_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        compare_word(name, XLEN'(got), XLEN'(exp));
    endtask

    task automatic check_resolve(input br_resolve_t got, input br_resolve_t exp);
        compare_word("res.pc", got.pc, exp.pc);
        check_flag("res.taken", got.taken, exp.taken);
        compare_word("res.target", got.target, exp.target);
        check_flag("res.dir_fail", got.dir_fail, exp.dir_fail);
        check_flag("res.addr_fail", got.addr_fail, exp.addr_fail);
        compare_word("res.redirect_pc", got.redirect_pc, exp.redirect_pc);
    endtask

    task automatic check_redirect(input logic got_v, input logic [XLEN-1:0] got_pc,
                                  input logic exp_v, input logic [XLEN-1:0] exp_pc);
        check_flag("redirect_valid", got_v, exp_v);
        if (exp_v) begin
            compare_word("redirect_pc", got_pc, exp_pc);
        end
    endtask

    task automatic report_test(input int tid);
        n_tests++;
        $display("test %0d %s: checks %0d errors %0d", tid,
                 test_names.exists(tid) ? test_names[tid] : "unnamed", t_checks, t_errors);
    endtask

    task automatic check_outputs();
        logic        v;
        br_resolve_t exp;
        int          tid;
        v   = exp_v_q.pop_front();
        exp = exp_q.pop_front();
        tid = exp_t_q.pop_front();
        if (tid != cur_chk) begin
            if (cur_chk >= 0) report_test(cur_chk);
            cur_chk  = tid;
            t_checks = 0;
            t_errors = 0;
        end
        check_flag("res_valid", res_valid, v);
        if (v) begin
            check_resolve(res, exp);
        end
        check_redirect(redirect_valid, redirect_pc, v && exp.addr_fail, exp.redirect_pc);
    endtask

    initial begin
        stim_t flush;
        void'($urandom(38994));
        reset    = 1'b1;
        in_valid = 1'b0;
        in_req   = '0;
        pend_v   = 1'b0;
        for (int k = 0; k < ENTRIES; k++) begin
            m_valid[k] = 1'b0;
            m_cnt[k]   = 0;
        end
        load_stim();
        cycle_limit = RESET_CYCLES + ops.size() + LATENCY + MARGIN;
        flush = '0;
        if (ops.size() > 0) flush.test_id = ops[ops.size()-1].test_id;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < ops.size() + LATENCY; i++) begin
            @(negedge clk);
            if (exp_q.size() == LATENCY) check_outputs();
            if (i < ops.size()) begin
                apply_op(ops[i]);
            end else begin
                apply_op(flush);
            end
        end
        if (cur_chk >= 0) report_test(cur_chk);
        if (DUT.u_props.fail_count != 0) begin
            $display("assertion checks failed %0d times", DUT.u_props.fail_count);
            n_errors += DUT.u_props.fail_count;
        end
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verification/branch_stim.txt
# valid pc imm sr1 sr2 cond is_branch exp_taken exp_target, all hex
# valid 0 is a bubble, 2 is a filler whose sr2 and expected result come from the testbench
@ 1 condition_codes
1 00001000 00000100 00000005 00000005 6 1 1 00001100
1 00001004 00000100 00000005 00000006 6 1 0 00001104
1 00001008 00000100 00000005 00000006 7 1 1 00001108
1 0000100c 00000100 00000007 00000007 7 1 0 0000110c
1 00001010 00000100 80000000 00000001 8 1 1 00001110
1 00001014 00000100 80000000 00000001 a 1 0 00001114
1 00001018 00000100 80000000 00000001 9 1 0 00001118
1 0000101c 00000100 80000000 00000001 b 1 1 0000111c
1 00001020 00000100 ffffffff ffffffff 8 1 0 00001120
1 00001024 00000100 ffffffff ffffffff 9 1 1 00001124
1 00001028 fffffff0 00000000 00000000 4 1 1 00001018
1 0000102c 00000200 00000000 00000000 5 1 1 0000122c
1 00001030 00000010 00004000 00000000 3 1 1 00004010
1 00001034 00000100 00000000 00000000 0 1 0 00001134
1 00001038 00000100 00000003 00000003 6 0 0 00001138
1 0000103c 00000100 00000001 80000000 a 1 1 0000113c
2 00002000 00000100 80000000 00000000 a 1 0 00000000
2 00002004 00000100 00000000 00000000 9 1 0 00000000
2 00002008 00000100 12345678 00000000 7 1 0 00000000
@ 2 cold_then_trained
1 00003000 00000040 00000001 00000002 7 1 1 00003040
0 00000000 00000000 00000000 00000000 0 0 0 00000000
1 00003000 00000040 00000001 00000002 7 1 1 00003040
1 00003000 00000040 00000001 00000002 7 1 1 00003040
@ 3 jirl_new_target
1 00004000 00000000 00005000 00000000 3 1 1 00005000
0 00000000 00000000 00000000 00000000 0 0 0 00000000
1 00004000 00000000 00005000 00000000 3 1 1 00005000
1 00004000 00000000 00006000 00000000 3 1 1 00006000
@ 4 condition_turns_false
1 00005004 00000020 00000009 00000009 6 1 1 00005024
0 00000000 00000000 00000000 00000000 0 0 0 00000000
1 00005004 00000020 00000009 00000009 6 1 1 00005024
0 00000000 00000000 00000000 00000000 0 0 0 00000000
1 00005004 00000020 00000009 0000000a 6 1 0 00005024
0 00000000 00000000 00000000 00000000 0 0 0 00000000
1 00005004 00000020 00000009 0000000a 6 1 0 00005024
0 00000000 00000000 00000000 00000000 0 0 0 00000000
1 00005004 00000020 00000009 0000000a 6 1 0 00005024
0 00000000 00000000 00000000 00000000 0 0 0 00000000
1 00005004 00000020 00000009 00000009 6 1 1 00005024
@ 5 back_to_back_stale
1 00006008 00000100 00000000 00000000 4 1 1 00006108
1 00006008 00000100 00000000 00000000 4 1 1 00006108
1 00006008 00000100 00000000 00000000 4 1 1 00006108
1 00006008 00000100 00000000 00000000 4 1 1 00006108
0 00000000 00000000 00000000 00000000 0 0 0 00000000
0 00000000 00000000 00000000 00000000 0 0 0 00000000
0 00000000 00000000 00000000 00000000 0 0 0 00000000
@ 6 non_branch_alias
1 00006008 00000100 00000000 00000000 0 0 0 00006108
1 00006008 00000100 00000000 00000000 0 0 0 00006108
1 00006008 00000100 00000000 00000000 4 1 1 00006108
0 00000000 00000000 00000000 00000000 0 0 0 00000000
